//--- Bender.yml
package:
  name: fifo_ctrl_1r1w

sources:
  - fifo_cfg_pkg.sv
  - fifo_types_pkg.sv
  - fifo_ram.sv
  - fifo_staging_buffer.sv
  - fifo_push_ctrl.sv
  - fifo_pop_ctrl.sv
  - fifo_ctrl_1r1w.sv
  - target: test
    files:
      - tb_fifo.sv

//--- compile.f
fifo_cfg_pkg.sv
fifo_types_pkg.sv
fifo_ram.sv
fifo_staging_buffer.sv
fifo_push_ctrl.sv
fifo_pop_ctrl.sv
fifo_ctrl_1r1w.sv
tb_fifo.sv

//--- fifo_cfg_pkg.sv
// --------------------------------------------------------------------------
// FIFO configuration
// Fixed depth, width and array read latency of the register-file FIFO,
// with the staging size, array depth and field widths derived from them
// --------------------------------------------------------------------------

package fifo_cfg_pkg;

  // ------------------------------------------------------------------------
  // Base configuration
  // ------------------------------------------------------------------------

  // Total capacity in items, array plus staging buffer
  localparam int fifo_depth = 8;

  // Payload width
  localparam int fifo_width = 16;

  // Cycles from read address to read data
  localparam int ram_read_latency = 1;

  // ------------------------------------------------------------------------
  // Derived sizes
  // ------------------------------------------------------------------------

  // One entry per read in flight, plus one to hold the head
  localparam int staging_depth = ram_read_latency + 1;

  // Smallest array that still gives fifo_depth in total
  localparam int ram_depth = fifo_depth - staging_depth;

  localparam int addr_width = $clog2(ram_depth);
  localparam int count_width = $clog2(fifo_depth + 1);

  // Array address step, wraps at ram_depth which is not a power of two
  function automatic logic [addr_width-1:0] addr_incr(input logic [addr_width-1:0] addr);
    logic [addr_width-1:0] last;
    last = addr_width'(ram_depth - 1);
    return (addr == last) ? '0 : addr + 1'b1;
  endfunction

endpackage : fifo_cfg_pkg

//--- fifo_ctrl_1r1w.sv
// --------------------------------------------------------------------------
// FIFO top level
// Single-clock FIFO built from a push controller, a pop controller with
// its staging buffer, and a 1R1W storage array
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_ctrl_1r1w
  import fifo_cfg_pkg::*, fifo_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // Push side
  input  logic                  push_valid,
  input  logic [fifo_width-1:0] push_data,
  output logic                  push_ready,

  // Pop side
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output logic [fifo_width-1:0] pop_data,

  // Status
  output occupancy_t            occ
);

  // Push to pop
  logic                  bypass_valid;
  logic [fifo_width-1:0] bypass_data;

  // Pop to push
  logic                  bypass_ready;
  logic                  pop_beat;

  // Array ports
  ram_wr_t               ram_wr;
  ram_rd_req_t           ram_rd_req;
  ram_rd_rsp_t           ram_rd_rsp;

  fifo_push_ctrl i_fifo_push_ctrl (
    .clk          (clk),
    .rst          (rst),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .push_ready   (push_ready),
    .bypass_ready (bypass_ready),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .ram_wr       (ram_wr),
    .pop_beat     (pop_beat),
    .occ          (occ)
  );

  fifo_pop_ctrl i_fifo_pop_ctrl (
    .clk          (clk),
    .rst          (rst),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .bypass_ready (bypass_ready),
    .ram_rd_req   (ram_rd_req),
    .ram_rd_rsp   (ram_rd_rsp),
    .occ          (occ),
    .pop_beat     (pop_beat)
  );

  fifo_ram i_fifo_ram (
    .clk        (clk),
    .rst        (rst),
    .ram_wr     (ram_wr),
    .ram_rd_req (ram_rd_req),
    .ram_rd_rsp (ram_rd_rsp)
  );

endmodule : fifo_ctrl_1r1w

//--- fifo_pop_ctrl.sv
// --------------------------------------------------------------------------
// FIFO pop controller
// Read address counter and pop beat around the staging buffer, which
// decides between array data and bypassed items
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_pop_ctrl
  import fifo_cfg_pkg::*, fifo_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // Pop side
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output logic [fifo_width-1:0] pop_data,

  // Bypass from the push side
  input  logic                  bypass_valid,
  input  logic [fifo_width-1:0] bypass_data,
  output logic                  bypass_ready,

  // Array read port
  output ram_rd_req_t           ram_rd_req,
  input  ram_rd_rsp_t           ram_rd_rsp,

  // Occupancy is tracked by the push side
  input  occupancy_t            occ,
  output logic                  pop_beat
);

  logic                  ram_rd_valid;
  logic [addr_width-1:0] rd_addr;

  // ------------------------------------------------------------------------
  // Flow control
  // ------------------------------------------------------------------------

  assign pop_beat = pop_valid && pop_ready;

  // ------------------------------------------------------------------------
  // Read address
  // ------------------------------------------------------------------------

  // Steps once per issued read, same wrap point as the write side
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
    end else if (ram_rd_valid) begin
      rd_addr <= addr_incr(rd_addr);
    end
  end

  assign ram_rd_req.valid = ram_rd_valid;
  assign ram_rd_req.addr  = rd_addr;

  // ------------------------------------------------------------------------
  // Staging buffer
  // ------------------------------------------------------------------------

  // Hides the read latency, takes bypassed items when the array is empty
  fifo_staging_buffer i_fifo_staging_buffer (
    .clk          (clk),
    .rst          (rst),
    .total_items  (occ.items),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .bypass_ready (bypass_ready),
    .ram_rd_valid (ram_rd_valid),
    .ram_rd_rsp   (ram_rd_rsp),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data)
  );

endmodule : fifo_pop_ctrl

//--- fifo_push_ctrl.sv
// --------------------------------------------------------------------------
// FIFO push controller
// Accepts pushes while not full, steers each item to the bypass path or
// the array, and keeps the write address and the total item count
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_push_ctrl
  import fifo_cfg_pkg::*, fifo_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // Push side
  input  logic                  push_valid,
  input  logic [fifo_width-1:0] push_data,
  output logic                  push_ready,

  // Bypass into the staging buffer
  input  logic                  bypass_ready,
  output logic                  bypass_valid,
  output logic [fifo_width-1:0] bypass_data,

  // Array write port
  output ram_wr_t               ram_wr,

  // From the pop side
  input  logic                  pop_beat,
  output occupancy_t            occ
);

  logic                   push_beat;
  logic [addr_width-1:0]  wr_addr;
  logic [count_width-1:0] items_q;

  // ------------------------------------------------------------------------
  // Flow control
  // ------------------------------------------------------------------------

  // Only registered state here, so no path from pop_ready
  assign push_ready = !occ.full;
  assign push_beat  = push_valid && push_ready;

  // Bypass offer goes out with every push beat
  // The staging buffer takes it only while bypass_ready is high
  assign bypass_valid = push_beat;
  assign bypass_data  = push_data;

  // Everything not bypassed lands in the array
  assign ram_wr.valid = push_beat && !bypass_ready;
  assign ram_wr.addr  = wr_addr;
  assign ram_wr.data  = push_data;

  // ------------------------------------------------------------------------
  // Write address
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_addr <= '0;
    end else if (ram_wr.valid) begin
      wr_addr <= addr_incr(wr_addr);
    end
  end

  // ------------------------------------------------------------------------
  // Item count
  // ------------------------------------------------------------------------

  // Push and pop together leave the count alone
  always_ff @(posedge clk) begin
    if (rst) begin
      items_q <= '0;
    end else if (push_beat && !pop_beat) begin
      items_q <= items_q + 1'b1;
    end else if (pop_beat && !push_beat) begin
      items_q <= items_q - 1'b1;
    end
  end

  assign occ.items = items_q;
  assign occ.empty = (items_q == '0);
  assign occ.full  = (items_q == count_width'(fifo_depth));

endmodule : fifo_push_ctrl

//--- fifo_ram.sv
// --------------------------------------------------------------------------
// FIFO storage array
// Flop array of ram_depth words, one write port and one read port with
// the read data registered one cycle after the address
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_ram
  import fifo_cfg_pkg::*, fifo_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  ram_wr_t     ram_wr,
  input  ram_rd_req_t ram_rd_req,
  output ram_rd_rsp_t ram_rd_rsp
);

  logic [fifo_width-1:0] mem [ram_depth];
  logic                  rd_valid_q;
  logic [fifo_width-1:0] rd_data_q;

  // Write port
  always_ff @(posedge clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Read valid, the only control state here
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= ram_rd_req.valid;
    end
  end

  // Read data, a word written last cycle is already visible
  always_ff @(posedge clk) begin
    if (ram_rd_req.valid) begin
      rd_data_q <= mem[ram_rd_req.addr];
    end
  end

  assign ram_rd_rsp.valid = rd_valid_q;
  assign ram_rd_rsp.data  = rd_data_q;

endmodule : fifo_ram

//--- fifo_staging_buffer.sv
// --------------------------------------------------------------------------
// FIFO staging buffer
// Two-entry output buffer in front of the array. Issues array reads while
// it has room, catches read data and bypassed items, and drives the pop
// port in arrival order
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module fifo_staging_buffer
  import fifo_cfg_pkg::*, fifo_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // Total items in the FIFO, from the push side
  input  logic [count_width-1:0] total_items,

  // Bypass path
  input  logic                   bypass_valid,
  input  logic [fifo_width-1:0]  bypass_data,
  output logic                   bypass_ready,

  // Array read
  output logic                   ram_rd_valid,
  input  ram_rd_rsp_t            ram_rd_rsp,

  // Pop side
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output logic [fifo_width-1:0]  pop_data
);

  staging_state_e         state, state_d;
  logic                   inflight_q;
  logic [count_width-1:0] staged_count;
  logic [count_width-1:0] array_items;
  logic [count_width-1:0] pipe_load;
  logic                   pop_take;
  logic                   in_valid;
  logic [fifo_width-1:0]  in_data;
  logic [fifo_width-1:0]  head_q;
  logic [fifo_width-1:0]  tail_q;

  // ------------------------------------------------------------------------
  // Occupancy bookkeeping
  // ------------------------------------------------------------------------

  always_comb begin
    case (state)
      stg_empty: staged_count = '0;
      stg_one:   staged_count = count_width'(1);
      default:   staged_count = count_width'(2);
    endcase
  end

  // Items still sitting in the array
  assign array_items = total_items - staged_count - count_width'(inflight_q);

  assign pop_valid = (state != stg_empty);
  assign pop_data  = head_q;
  assign pop_take  = pop_valid && pop_ready;

  // Slots taken after this cycle's pop, never negative
  assign pipe_load = staged_count + count_width'(inflight_q) - count_width'(pop_take);

  assign ram_rd_valid = (array_items != '0) && (pipe_load < count_width'(staging_depth));

  // Bypass keeps order only with nothing older in the array or in flight
  assign bypass_ready = (array_items == '0) && !inflight_q && (state != stg_two);

  // Read data and bypass never arrive together
  assign in_valid = ram_rd_rsp.valid || (bypass_valid && bypass_ready);
  assign in_data  = ram_rd_rsp.valid ? ram_rd_rsp.data : bypass_data;

  // ------------------------------------------------------------------------
  // Entry state
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state;
    case (state)
      stg_empty: if (in_valid) state_d = stg_one;
      stg_one: begin
        if (in_valid && !pop_take) state_d = stg_two;
        else if (!in_valid && pop_take) state_d = stg_empty;
      end
      default: if (pop_take && !in_valid) state_d = stg_one;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= stg_empty;
      inflight_q <= 1'b0;
    end else begin
      state      <= state_d;
      inflight_q <= ram_rd_valid;
    end
  end

  // ------------------------------------------------------------------------
  // Entry data
  // ------------------------------------------------------------------------

  // Head drains first, tail moves up on a pop
  always_ff @(posedge clk) begin
    if (state == stg_two && pop_take) begin
      head_q <= tail_q;
    end else if (in_valid && (state == stg_empty || (state == stg_one && pop_take))) begin
      head_q <= in_data;
    end
    if (in_valid && (state == stg_two || (state == stg_one && !pop_take))) begin
      tail_q <= in_data;
    end
  end

endmodule : fifo_staging_buffer

//--- fifo_types_pkg.sv
// --------------------------------------------------------------------------
// FIFO types
// Packed bundles for the array ports and occupancy status, and the state
// encoding of the staging buffer
// --------------------------------------------------------------------------

package fifo_types_pkg;

  import fifo_cfg_pkg::*;

  // Array write port, one request per cycle
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic [fifo_width-1:0] data;
  } ram_wr_t;

  // Array read address
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
  } ram_rd_req_t;

  // Read data, one cycle behind its request
  typedef struct packed {
    logic                  valid;
    logic [fifo_width-1:0] data;
  } ram_rd_rsp_t;

  // Occupancy, kept by the push side
  typedef struct packed {
    logic [count_width-1:0] items;
    logic                   empty;
    logic                   full;
  } occupancy_t;

  // Number of entries held in the staging buffer
  typedef enum logic [1:0] {
    stg_empty,
    stg_one,
    stg_two
  } staging_state_e;

endpackage : fifo_types_pkg

//--- tb_fifo.sv
// --------------------------------------------------------------------------
// FIFO testbench
// Drives the register-file FIFO through reset, bypass, array ordering,
// full and back-pressure, random traffic and steady push/pop, and checks
// it against a queue reference model
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_fifo
  import fifo_cfg_pkg::*, fifo_types_pkg::*;
();

  logic                  clk;
  logic                  rst;
  logic                  push_valid;
  logic [fifo_width-1:0] push_data;
  logic                  push_ready;
  logic                  pop_ready;
  logic                  pop_valid;
  logic [fifo_width-1:0] pop_data;
  occupancy_t            occ;

  // Reference model and bookkeeping
  logic [fifo_width-1:0] model_q[$];
  logic                  push_taken = 1'b0;
  logic                  pop_hold = 1'b0;
  logic [fifo_width-1:0] held_data;
  integer                seed = 32'h9012;
  int                    timeout_cycles = 64;
  int                    err_count = 0;
  int                    pass_count = 0;
  int                    fail_count = 0;

  fifo_ctrl_1r1w i_fifo_ctrl_1r1w (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .occ        (occ)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // Called and left at 1 ns after a rising edge
  task automatic push_item(input logic [fifo_width-1:0] d);
    int n;
    n = 0;
    push_valid = 1'b1;
    push_data  = d;
    @(negedge clk);
    while (!push_ready && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!push_ready) begin
      $display("Timeout: push was not accepted within %0d cycles", n);
      err_count++;
    end
    @(posedge clk);
    #1;
    push_valid = 1'b0;
  endtask

  task automatic drain_fifo();
    int n;
    n = 0;
    pop_ready = 1'b1;
    @(negedge clk);
    while ((pop_valid || !occ.empty) && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (pop_valid || !occ.empty) begin
      $display("Timeout: FIFO still holds items after %0d cycles of draining", n);
      err_count++;
    end
    @(posedge clk);
    #1;
    pop_ready = 1'b0;
  endtask

  task automatic end_test(input string name, input int mark);
    if (err_count == mark) begin
      pass_count++;
      $display("PASS  %s", name);
    end else begin
      fail_count++;
      $display("FAIL  %s, %0d errors", name, err_count - mark);
    end
  endtask

  // ------------------------------------------------------------------------
  // Monitor samples between edges where everything has settled
  // ------------------------------------------------------------------------

  always @(negedge clk) begin
    if (rst) begin
      pop_hold   = 1'b0;
      push_taken = 1'b0;
    end else begin
      // Count reflects the beats of the previous edge
      compare("occ.items", occ.items, model_q.size());
      compare("occ.empty", occ.empty, model_q.size() == 0);
      compare("occ.full", occ.full, model_q.size() == fifo_depth);
      // Push side stalls only when full
      compare("push_ready", push_ready, model_q.size() < fifo_depth);
      // Stalled output holds
      if (pop_hold) begin
        compare("pop_valid", pop_valid, 1);
        compare("pop_data", pop_data, held_data);
      end
      if (pop_valid && pop_ready) begin
        if (model_q.size() == 0) begin
          $display("Pop seen at %0t ns while the reference model is empty", $time);
          err_count++;
        end else begin
          compare("pop_data", pop_data, model_q.pop_front());
        end
      end
      if (push_valid && push_ready) begin
        model_q.push_back(push_data);
      end
      push_taken = push_valid && push_ready;
      pop_hold   = pop_valid && !pop_ready;
      held_data  = pop_data;
    end
  end

  // ------------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------------

  initial begin
    int                    mark;
    int                    i;
    logic [fifo_width-1:0] d;
    rst        = 1'b1;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    mark = err_count;
    @(negedge clk);
    compare("pop_valid", pop_valid, 0);
    compare("push_ready", push_ready, 1);
    compare("occ.items", occ.items, 0);
    compare("occ.empty", occ.empty, 1);
    @(posedge clk);
    #1;
    end_test("reset state", mark);

    // Item into an empty FIFO goes straight to staging
    mark = err_count;
    d = fifo_width'($random(seed));
    push_valid = 1'b1;
    push_data  = d;
    @(negedge clk);
    compare("pop_valid", pop_valid, 0);
    @(posedge clk);
    #1;
    push_valid = 1'b0;
    @(negedge clk);
    compare("pop_valid", pop_valid, 1);
    compare("pop_data", pop_data, d);
    @(posedge clk);
    #1;
    drain_fifo();
    end_test("bypass into empty FIFO", mark);

    // Fill through the array and drain in order
    mark = err_count;
    for (i = 0; i < fifo_depth; i++) begin
      push_item(fifo_width'($random(seed)));
    end
    drain_fifo();
    end_test("ordering through array", mark);

    mark = err_count;
    for (i = 0; i < fifo_depth; i++) begin
      push_item(fifo_width'($random(seed)));
    end
    @(negedge clk);
    compare("occ.full", occ.full, 1);
    compare("push_ready", push_ready, 0);
    d = pop_data;
    repeat (3) @(negedge clk);
    compare("pop_data", pop_data, d);
    @(posedge clk);
    #1;
    pop_ready = 1'b1;
    @(posedge clk);
    #1;
    pop_ready = 1'b0;
    @(negedge clk);
    compare("push_ready", push_ready, 1);
    compare("occ.items", occ.items, fifo_depth - 1);
    @(posedge clk);
    #1;
    drain_fifo();
    end_test("full and back-pressure", mark);

    // Random traffic where a pending push stays until taken
    mark = err_count;
    for (i = 0; i < 400; i++) begin
      if (!push_valid || push_taken) begin
        push_valid = ($random(seed) % 2) != 0;
        push_data  = fifo_width'($random(seed));
      end
      pop_ready = ($random(seed) % 3) != 0;
      @(posedge clk);
      #1;
    end
    pop_ready = 1'b1;
    push_item(push_data);
    drain_fifo();
    end_test("random traffic", mark);

    // Fill to half and then push and pop on every cycle
    mark = err_count;
    for (i = 0; i < 4; i++) begin
      push_item(fifo_width'($random(seed)));
    end
    for (i = 0; i < 24; i++) begin
      push_valid = 1'b1;
      push_data  = fifo_width'($random(seed));
      pop_ready  = 1'b1;
      @(negedge clk);
      compare("occ.items", occ.items, 4);
      compare("pop_valid", pop_valid, 1);
      @(posedge clk);
      #1;
    end
    push_valid = 1'b0;
    drain_fifo();
    end_test("steady push and pop", mark);

    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_fifo
